// ==== src/rename_defines.svh ====
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file size.
`define ARCH_REGS 16

// physical register file size.
`define PHYS_REGS 32

// tags not covered by the identity mapping.
// these seed the free list.
`define FREE_REGS (`PHYS_REGS - `ARCH_REGS)

// architectural index width.
`define ARCH_W 4

// physical tag width.
`define PHYS_W 5

// free list pointer width.
// the occupancy count needs one bit more.
`define FREE_W 4

`endif

// ==== src/rename_pkg.sv ====
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

  // index into the map table.
  typedef logic [`ARCH_W-1:0] arch_reg_t;

  // physical register tag.
  // this is the payload of every RAM in the slice.
  typedef logic [`PHYS_W-1:0] phys_reg_t;

  // head or tail slot of the circular free list.
  typedef logic [`FREE_W-1:0] free_ptr_t;

  // free list occupancy.
  // spans 0 up to and including FREE_REGS.
  typedef logic [`FREE_W:0] free_cnt_t;

endpackage

`default_nettype wire

// ==== src/pg_ram_1r1w.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_ram_1r1w #(
  parameter int unsigned DEPTH = 16
) (
  input  wire                       clk,
  input  wire                       pwrGate_i,
  input  wire  [$clog2(DEPTH)-1:0]  addr0_i,
  input  wire  [$clog2(DEPTH)-1:0]  addrWr_i,
  input  wire                       we_i,
  input  rename_pkg::phys_reg_t     data_i,
  output rename_pkg::phys_reg_t     data0_o
);

  import rename_pkg::*;

  // storage array, one tag per entry.
  phys_reg_t mem [DEPTH];

  // read is asynchronous.
  // a gated array already holds X everywhere, so the port returns X then.
  assign data0_o = mem[addr0_i];

  // power gate loses every location.
  // writes are dropped until the gate opens again.
  always_ff @(posedge clk or posedge pwrGate_i)
  begin
    if (pwrGate_i)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= 'x;
    end
    else if (we_i)
    begin
      // single write port, new data visible from the next cycle.
      mem[addrWr_i] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/free_list_ptrs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module free_list_ptrs (
  input  wire                    clk,
  input  wire                    pwrGate_i,
  input  wire                    load_i,
  input  wire                    pop_i,
  input  wire                    push_i,
  output rename_pkg::free_ptr_t  head_o,
  output rename_pkg::free_ptr_t  tail_o,
  output rename_pkg::free_cnt_t  count_o
);

  import rename_pkg::*;

  // last valid slot of the circular buffer.
  localparam free_ptr_t LAST_SLOT = free_ptr_t'(`FREE_REGS - 1);

  // list is full once the sweep has seeded it.
  localparam free_cnt_t FULL_CNT = free_cnt_t'(`FREE_REGS);

  // advance a pointer with explicit wrap.
  // depth need not be a power of two.
  function automatic free_ptr_t next_ptr(input free_ptr_t ptr);
    if (ptr == LAST_SLOT)
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // head pointer.
  // pops read the tag at head, then move on.
  always_ff @(posedge clk or posedge pwrGate_i)
  begin
    if (pwrGate_i)
      head_o <= '0;
    else if (load_i)
      head_o <= '0;
    else if (pop_i)
      head_o <= next_ptr(head_o);
  end

  // tail pointer.
  // committed tags land at tail.
  always_ff @(posedge clk or posedge pwrGate_i)
  begin
    if (pwrGate_i)
      tail_o <= '0;
    else if (load_i)
      tail_o <= '0;
    else if (push_i)
      tail_o <= next_ptr(tail_o);
  end

  // occupancy.
  // pop and push together cancel out.
  always_ff @(posedge clk or posedge pwrGate_i)
  begin
    if (pwrGate_i)
      count_o <= '0;
    else if (load_i)
      count_o <= FULL_CNT;
    else
    begin
      case ({pop_i, push_i})
        2'b10:   count_o <= count_o - 1'b1;
        2'b01:   count_o <= count_o + 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/rename_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_ctrl (
  input  wire                    clk,
  input  wire                    pwrGate_i,
  input  wire                    rename_valid_i,
  input  wire                    has_dst_i,
  input  rename_pkg::arch_reg_t  dst_arch_i,
  input  wire                    commit_valid_i,
  input  rename_pkg::phys_reg_t  commit_phys_i,
  input  rename_pkg::phys_reg_t  new_phys_i,
  input  rename_pkg::free_ptr_t  tail_i,
  input  rename_pkg::free_cnt_t  count_i,
  output logic                   rename_ready_o,
  output logic                   map_we_o,
  output rename_pkg::arch_reg_t  map_waddr_o,
  output rename_pkg::phys_reg_t  map_wdata_o,
  output logic                   free_we_o,
  output rename_pkg::free_ptr_t  free_waddr_o,
  output rename_pkg::phys_reg_t  free_wdata_o,
  output logic                   load_o,
  output logic                   pop_o,
  output logic                   push_o
);

  import rename_pkg::*;

  // final sweep index.
  localparam arch_reg_t LAST_STEP = arch_reg_t'(`ARCH_REGS - 1);

  // sweep state.
  arch_reg_t init_cnt;
  logic      init_done;
  logic      sweeping;
  logic      rename_fire;

  // sweep runs from the first edge after the gate opens.
  assign sweeping = !init_done;

  // one sweep step per edge, then hold until the next power gate.
  always_ff @(posedge clk or posedge pwrGate_i)
  begin
    if (pwrGate_i)
    begin
      init_cnt  <= '0;
      init_done <= 1'b0;
    end
    else if (sweeping)
    begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == LAST_STEP)
        init_done <= 1'b1;
    end
  end

  // ready needs a finished sweep and at least one free tag.
  assign rename_ready_o = init_done && (count_i != '0);

  // handshake on the rename side.
  assign rename_fire = rename_valid_i && rename_ready_o;

  // only a destination consumes a tag.
  assign pop_o = rename_fire && has_dst_i;

  // commits are dropped until the list has been seeded.
  assign push_o = commit_valid_i && init_done;

  // pointers take the full count on the last sweep step.
  assign load_o = sweeping && (init_cnt == LAST_STEP);

  // map table write port.
  // sweep writes the identity mapping, then renames write the new tag.
  always_comb
  begin
    if (sweeping)
    begin
      map_we_o    = 1'b1;
      map_waddr_o = init_cnt;
      map_wdata_o = phys_reg_t'(init_cnt);
    end
    else
    begin
      map_we_o    = pop_o;
      map_waddr_o = dst_arch_i;
      map_wdata_o = new_phys_i;
    end
  end

  // free list write port.
  // seed tags sit directly above the architectural range.
  always_comb
  begin
    if (sweeping)
    begin
      free_we_o    = 1'b1;
      free_waddr_o = free_ptr_t'(init_cnt);
      free_wdata_o = phys_reg_t'(`ARCH_REGS) + phys_reg_t'(init_cnt);
    end
    else
    begin
      free_we_o    = push_o;
      free_waddr_o = tail_i;
      free_wdata_o = commit_phys_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_top (
  input  wire                    clk,
  input  wire                    pwrGate_i,
  input  wire                    rename_valid_i,
  input  rename_pkg::arch_reg_t  src_arch_i,
  input  rename_pkg::arch_reg_t  dst_arch_i,
  input  wire                    has_dst_i,
  input  wire                    commit_valid_i,
  input  rename_pkg::phys_reg_t  commit_phys_i,
  output logic                   rename_ready_o,
  output rename_pkg::phys_reg_t  src_phys_o,
  output rename_pkg::phys_reg_t  new_phys_o,
  output rename_pkg::phys_reg_t  old_phys_o
);

  import rename_pkg::*;

  // map table write port, shared by both map copies.
  logic      map_we;
  arch_reg_t map_waddr;
  phys_reg_t map_wdata;

  // free list write port.
  logic      free_we;
  free_ptr_t free_waddr;
  phys_reg_t free_wdata;

  // pointer control and state.
  logic      ptr_load;
  logic      ptr_pop;
  logic      ptr_push;
  free_ptr_t free_head;
  free_ptr_t free_tail;
  free_cnt_t free_count;

  // sweep, ready and write steering.
  rename_ctrl ctrl_i (
    .clk            (clk),
    .pwrGate_i      (pwrGate_i),
    .rename_valid_i (rename_valid_i),
    .has_dst_i      (has_dst_i),
    .dst_arch_i     (dst_arch_i),
    .commit_valid_i (commit_valid_i),
    .commit_phys_i  (commit_phys_i),
    .new_phys_i     (new_phys_o),
    .tail_i         (free_tail),
    .count_i        (free_count),
    .rename_ready_o (rename_ready_o),
    .map_we_o       (map_we),
    .map_waddr_o    (map_waddr),
    .map_wdata_o    (map_wdata),
    .free_we_o      (free_we),
    .free_waddr_o   (free_waddr),
    .free_wdata_o   (free_wdata),
    .load_o         (ptr_load),
    .pop_o          (ptr_pop),
    .push_o         (ptr_push)
  );

  // circular free list bookkeeping.
  free_list_ptrs ptrs_i (
    .clk       (clk),
    .pwrGate_i (pwrGate_i),
    .load_i    (ptr_load),
    .pop_i     (ptr_pop),
    .push_i    (ptr_push),
    .head_o    (free_head),
    .tail_o    (free_tail),
    .count_o   (free_count)
  );

  // map copy read by the source index.
  pg_ram_1r1w #(.DEPTH(`ARCH_REGS)) map_src_ram (
    .clk       (clk),
    .pwrGate_i (pwrGate_i),
    .addr0_i   (src_arch_i),
    .addrWr_i  (map_waddr),
    .we_i      (map_we),
    .data_i    (map_wdata),
    .data0_o   (src_phys_o)
  );

  // map copy read by the destination index.
  // gives the old mapping of the renamed register.
  pg_ram_1r1w #(.DEPTH(`ARCH_REGS)) map_dst_ram (
    .clk       (clk),
    .pwrGate_i (pwrGate_i),
    .addr0_i   (dst_arch_i),
    .addrWr_i  (map_waddr),
    .we_i      (map_we),
    .data_i    (map_wdata),
    .data0_o   (old_phys_o)
  );

  // free tag storage, read at head.
  pg_ram_1r1w #(.DEPTH(`FREE_REGS)) free_ram (
    .clk       (clk),
    .pwrGate_i (pwrGate_i),
    .addr0_i   (free_head),
    .addrWr_i  (free_waddr),
    .we_i      (free_we),
    .data_i    (free_wdata),
    .data0_o   (new_phys_o)
  );

endmodule

`default_nettype wire

// ==== sim/rename_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_checker (
  input  wire                    clk,
  input  wire                    pwrGate_i,
  input  wire                    rename_valid_i,
  input  rename_pkg::arch_reg_t  src_arch_i,
  input  rename_pkg::arch_reg_t  dst_arch_i,
  input  wire                    has_dst_i,
  input  wire                    commit_valid_i,
  input  rename_pkg::phys_reg_t  commit_phys_i,
  input  wire                    rename_ready_i,
  input  rename_pkg::phys_reg_t  src_phys_i,
  input  rename_pkg::phys_reg_t  new_phys_i,
  input  rename_pkg::phys_reg_t  old_phys_i,
  output int                     value_errs_o,
  output int                     ready_errs_o
);

  import rename_pkg::*;

  localparam int PW = `PHYS_W;

  // reference map table and free FIFO.
  phys_reg_t       ref_map [`ARCH_REGS];
  phys_reg_t       free_q [$];
  // edges seen since the gate opened, saturates at the sweep length.
  int              init_edges = 0;
  int              value_errs = 0;
  int              ready_errs = 0;
  logic            exp_ready;
  logic [3*PW-1:0] exp_tags;

  assign value_errs_o = value_errs;
  assign ready_errs_o = ready_errs;

  // expected {src, new, old} for one rename.
  // new is the oldest entry of the free FIFO.
  function automatic logic [3*PW-1:0] expect_tags(input arch_reg_t src, input arch_reg_t dst);
    return {ref_map[src], free_q[0], ref_map[dst]};
  endfunction

  // contents the sweep leaves behind.
  // identity map, then the tags above the architectural range in order.
  task automatic reset_model();
    free_q.delete();
    for (int k = 0; k < `ARCH_REGS; k++)
      ref_map[k] = phys_reg_t'(k);
    for (int k = 0; k < `FREE_REGS; k++)
      free_q.push_back(phys_reg_t'(`ARCH_REGS + k));
    init_edges = 0;
  endtask

  task automatic compare_tag(input string name, input phys_reg_t got, input phys_reg_t exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_ready(input logic exp);
    if (rename_ready_i !== exp)
    begin
      ready_errs++;
      $display("FAILED rename_ready_o: got 0x%h, expected 0x%h at %0t",
               rename_ready_i, exp, $time);
    end
  endtask

  // inputs settle on the falling edge, so everything is stable here.
  always @(posedge clk)
  begin
    if (pwrGate_i)
    begin
      reset_model();
      compare_ready(1'b0);
    end
    else
    begin
      exp_ready = (init_edges >= `ARCH_REGS) && (free_q.size() != 0);
      compare_ready(exp_ready);
      // guard keeps an empty model FIFO from being read.
      if (rename_valid_i && rename_ready_i && free_q.size() != 0)
      begin
        exp_tags = expect_tags(src_arch_i, dst_arch_i);
        compare_tag("src_phys_o", src_phys_i, exp_tags[3*PW-1:2*PW]);
        compare_tag("new_phys_o", new_phys_i, exp_tags[2*PW-1:PW]);
        compare_tag("old_phys_o", old_phys_i, exp_tags[PW-1:0]);
        // only a destination takes a tag.
        if (has_dst_i)
          ref_map[dst_arch_i] = free_q.pop_front();
      end
      // commits count once the sweep is over.
      // pop is applied first, so an empty list gets no bypass.
      if (commit_valid_i && init_edges >= `ARCH_REGS)
        free_q.push_back(commit_phys_i);
      if (init_edges < `ARCH_REGS)
        init_edges++;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module tb_rename_top;

  import rename_pkg::*;

  // random cycles in each of the two phases.
  localparam int RAND_CYCLES = 400;
  // directed renames plus the drain burst and hold window.
  localparam int DIRECTED_CYCLES = 64;
  localparam int STIM_CYCLES = 2 * RAND_CYCLES + DIRECTED_CYCLES;
  // two gate windows of 4 gated cycles plus the sweep.
  localparam int INIT_CYCLES = 2 * (4 + `ARCH_REGS + 1);
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + INIT_CYCLES;

  logic      clk;
  logic      pwr_gate;
  logic      rename_valid;
  arch_reg_t src_arch;
  arch_reg_t dst_arch;
  logic      has_dst;
  logic      commit_valid;
  phys_reg_t commit_phys;
  logic      rename_ready;
  phys_reg_t src_phys;
  phys_reg_t new_phys;
  phys_reg_t old_phys;

  int          value_errs;
  int          ready_errs;
  int          flow_errs = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr = 32'hdb8;
  // old tags renamed away are the only ones that may be committed.
  phys_reg_t   retire_q [$];

  rename_top dut_i (
    .clk            (clk),
    .pwrGate_i      (pwr_gate),
    .rename_valid_i (rename_valid),
    .src_arch_i     (src_arch),
    .dst_arch_i     (dst_arch),
    .has_dst_i      (has_dst),
    .commit_valid_i (commit_valid),
    .commit_phys_i  (commit_phys),
    .rename_ready_o (rename_ready),
    .src_phys_o     (src_phys),
    .new_phys_o     (new_phys),
    .old_phys_o     (old_phys)
  );

  rename_checker checker_i (
    .clk            (clk),
    .pwrGate_i      (pwr_gate),
    .rename_valid_i (rename_valid),
    .src_arch_i     (src_arch),
    .dst_arch_i     (dst_arch),
    .has_dst_i      (has_dst),
    .commit_valid_i (commit_valid),
    .commit_phys_i  (commit_phys),
    .rename_ready_i (rename_ready),
    .src_phys_i     (src_phys),
    .new_phys_i     (new_phys),
    .old_phys_i     (old_phys),
    .value_errs_o   (value_errs),
    .ready_errs_o   (ready_errs)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // drive on the falling edge and note acceptance at the rising edge.
  task automatic drive_cycle(input logic valid, input arch_reg_t src, input arch_reg_t dst,
                             input logic dst_en, input logic commit_en,
                             input phys_reg_t commit_tag, output logic taken);
    @(negedge clk);
    rename_valid = valid;
    src_arch     = src;
    dst_arch     = dst;
    has_dst      = dst_en;
    commit_valid = commit_en;
    commit_phys  = commit_tag;
    @(posedge clk);
    taken = valid && rename_ready;
    if (taken && dst_en)
      retire_q.push_back(old_phys);
  endtask

  task automatic rename_until_taken(input arch_reg_t src, input arch_reg_t dst,
                                    input logic dst_en);
    logic taken;
    taken = 1'b0;
    while (!taken)
      drive_cycle(1'b1, src, dst, dst_en, 1'b0, '0, taken);
  endtask

  // half of the cycles commit a randomly chosen outstanding tag.
  task automatic pick_commit(output logic en, output phys_reg_t tag);
    int idx;
    en  = 1'b0;
    tag = '0;
    if (retire_q.size() != 0 && take_bits(1) == 1)
    begin
      idx = int'(take_bits(5)) % retire_q.size();
      en  = 1'b1;
      tag = retire_q[idx];
      retire_q.delete(idx);
    end
  endtask

  // gate for 4 cycles and then wait out the sweep.
  // starts at time zero or on a falling edge.
  // every tag in flight is lost with the state.
  task automatic gate_power();
    rename_valid = 1'b0;
    commit_valid = 1'b0;
    pwr_gate     = 1'b1;
    retire_q.delete();
    repeat (4) @(negedge clk);
    pwr_gate = 1'b0;
    while (rename_ready !== 1'b1)
      @(negedge clk);
  endtask

  // identity reads first and then a few renames read back.
  task automatic check_after_init();
    for (int i = 0; i < `ARCH_REGS; i++)
      rename_until_taken(arch_reg_t'(i), arch_reg_t'(i), 1'b0);
    for (int i = 0; i < 4; i++)
      rename_until_taken(arch_reg_t'(i), arch_reg_t'(i), 1'b1);
    for (int i = 0; i < 4; i++)
      rename_until_taken(arch_reg_t'(i), arch_reg_t'(3 - i), 1'b0);
  endtask

  task automatic run_random(input int cycles);
    logic      v;
    logic      hd;
    logic      ce;
    logic      taken;
    arch_reg_t s;
    arch_reg_t d;
    phys_reg_t t;
    for (int n = 0; n < cycles; n++)
    begin
      v  = |take_bits(2);
      s  = arch_reg_t'(take_bits(`ARCH_W));
      d  = arch_reg_t'(take_bits(`ARCH_W));
      hd = take_bits(1) == 1;
      pick_commit(ce, t);
      drive_cycle(v, s, d, hd, ce, t, taken);
    end
  endtask

  // empty the full list and hold a request until one tag is freed.
  task automatic drain_and_hold();
    logic      taken;
    arch_reg_t d;
    for (int i = 0; i < `FREE_REGS; i++)
      rename_until_taken(arch_reg_t'(take_bits(`ARCH_W)), arch_reg_t'(i), 1'b1);
    d = arch_reg_t'(take_bits(`ARCH_W));
    for (int i = 0; i < 6; i++)
    begin
      drive_cycle(1'b1, '0, d, 1'b1, 1'b0, '0, taken);
      if (taken)
      begin
        flow_errs++;
        $display("held rename was consumed while the free list was empty at %0t", $time);
      end
    end
    // push lands at this edge, so the request still waits here.
    drive_cycle(1'b1, '0, d, 1'b1, 1'b1, retire_q.pop_front(), taken);
    if (taken)
    begin
      flow_errs++;
      $display("held rename was consumed in the same cycle as the commit at %0t", $time);
    end
    rename_until_taken('0, d, 1'b1);
  endtask

  // run length guard.
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the stimulus did not complete", cycle_cnt);
      $display("error counts: value %0d, ready %0d, flow %0d", value_errs, ready_errs,
               flow_errs);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial
  begin
    pwr_gate     = 1'b1;
    rename_valid = 1'b0;
    src_arch     = '0;
    dst_arch     = '0;
    has_dst      = 1'b0;
    commit_valid = 1'b0;
    commit_phys  = '0;
    gate_power();
    check_after_init();
    run_random(RAND_CYCLES);
    // mid-run gate.
    @(negedge clk);
    gate_power();
    drain_and_hold();
    run_random(RAND_CYCLES);
    @(negedge clk);
    rename_valid = 1'b0;
    commit_valid = 1'b0;
    repeat (4) @(negedge clk);
    $display("error counts: value %0d, ready %0d, flow %0d", value_errs, ready_errs, flow_errs);
    if (value_errs == 0 && ready_errs == 0 && flow_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rename_unit.f ====
+incdir+src
src/rename_pkg.sv
src/pg_ram_1r1w.sv
src/free_list_ptrs.sv
src/rename_ctrl.sv
src/rename_top.sv
sim/rename_checker.sv
sim/tb_rename_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rename testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_rename_top -f rename_unit.f \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vtb_rename_top > sim.log 2>&1 \
  || { echo "build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log \
  && { echo "result: fail"; exit 1; } \
  || { echo "result: pass"; exit 0; }
